// File: build.f
+incdir+.
vector_core_pkg.sv
decode_execute_register.sv
forward_unit.sv
scalar_alu.sv
vector_lane.sv
execute_writeback_register.sv
vector_execute_slice.sv
vector_execute_checker.sv
tb_vector_execute_slice.sv

// File: Bender.yml
package:
  name: vector_execute_slice

export_include_dirs:
  - .

sources:
  - vector_core_pkg.sv
  - decode_execute_register.sv
  - forward_unit.sv
  - scalar_alu.sv
  - vector_lane.sv
  - execute_writeback_register.sv
  - vector_execute_slice.sv
  - target: test
    files:
      - vector_execute_checker.sv
      - tb_vector_execute_slice.sv

// File: tb_vector_execute_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module tb_vector_execute_slice;

	localparam int ROW_MAX = 32;
	// mixed-sign elements for signed max and min
	localparam logic [127:0] MIXED_A = {4{16'hfff0, 16'h0010}};
	localparam logic [127:0] MIXED_B = {4{16'h0005, 16'h8000}};

	logic clk;
	logic reset;
	logic [`CTRL_WIDTH-1:0] control_word;
	logic [`SCALAR_WIDTH-1:0] src_a, src_b, mem_read_data;
	logic [`VECTOR_WIDTH-1:0] src_a_vector, src_b_vector, mem_vector_read_data;
	logic [`REG_ADDR_WIDTH-1:0] rs1, rs2, rd;
	logic wre, vector_wre, mem_we_a, mem_we_b;
	logic [`REG_ADDR_WIDTH-1:0] rd_writeback;
	logic [`SCALAR_WIDTH-1:0] writeback_data;
	logic [`VECTOR_WIDTH-1:0] vector_writeback_data;
	int row_tag;
	logic [127:0] row_name;
	int error_count, rows_passed, rows_failed;

	// stimulus table
	logic [127:0] name_table [ROW_MAX];
	logic [19:0] ctrl_table [ROW_MAX];
	logic [15:0] a_table [ROW_MAX], b_table [ROW_MAX], load_table [ROW_MAX];
	logic [127:0] av_table [ROW_MAX], bv_table [ROW_MAX];
	logic [4:0] rs1_table [ROW_MAX], rs2_table [ROW_MAX], rd_table [ROW_MAX];
	logic rand_table [ROW_MAX];
	int row_count;

	vector_execute_slice i_dut (.*);
	vector_execute_checker i_checker (.*);

	function automatic logic [19:0] ctrl_word(input logic ld, wr, vwr, wa, wb,
		input logic [1:0] ws, vws, input logic [3:0] aop, vop);
		return {3'b000, ld, wr, vwr, wa, wb, ws, vws, aop, vop};
	endfunction

	task automatic add_row(input logic [127:0] name, input logic [19:0] ctrl,
		input logic [15:0] a, b, input logic [127:0] av, bv,
		input logic [4:0] s1, s2, d, input logic [15:0] ld, input logic rnd);
		name_table[row_count] = name;
		ctrl_table[row_count] = ctrl;
		rand_table[row_count] = rnd;
		a_table[row_count] = a;
		b_table[row_count] = b;
		load_table[row_count] = ld;
		av_table[row_count] = av;
		bv_table[row_count] = bv;
		rs1_table[row_count] = s1;
		rs2_table[row_count] = s2;
		rd_table[row_count] = d;
		row_count++;
	endtask

	task automatic apply_step(input int k);
		if (k < row_count) begin
			control_word = ctrl_table[k];
			rs1 = rs1_table[k];
			rs2 = rs2_table[k];
			rd = rd_table[k];
			row_tag = k;
			row_name = name_table[k];
			src_a = a_table[k];
			src_b = b_table[k];
			src_a_vector = av_table[k];
			src_b_vector = bv_table[k];
			if (rand_table[k]) begin
				{src_a, src_b} = $urandom;
				src_a_vector = {$urandom, $urandom, $urandom, $urandom};
				src_b_vector = {$urandom, $urandom, $urandom, $urandom};
			end
		end else begin
			control_word = '0;
			row_tag = -1;
			row_name = '0;
		end
		// load data goes with the row that is now in execute
		mem_read_data = (k > 0 && k <= row_count) ? load_table[k-1] : '0;
		mem_vector_read_data = {4{mem_read_data, ~mem_read_data}};
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#1;
		#((16 + row_count + 8) * 40);
		$display("timeout: the pipeline did not finish its rows in time");
		$display("Checks failed");
		$finish;
	end

	initial begin : stimulus
		int unsigned seed_value;
		seed_value = 32'hd8d9fb9e;
		void'($urandom(seed_value));
		reset = 1'b1;
		control_word = '0;
		src_a = '0;
		src_b = '0;
		src_a_vector = '0;
		src_b_vector = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		mem_read_data = '0;
		mem_vector_read_data = '0;
		row_name = '0;
		row_tag = -1;
		row_count = 0;
		add_row("add_vadd", ctrl_word(0,1,1,0,0,0,0,0,0), 0, 0, 0, 0, 1, 2, 3, 0, 1);
		add_row("sub_vsub", ctrl_word(0,1,1,0,0,0,0,1,1), 0, 0, 0, 0, 4, 5, 6, 0, 1);
		add_row("and_vand", ctrl_word(0,1,1,0,0,0,0,2,2), 0, 0, 0, 0, 7, 8, 13, 0, 1);
		add_row("or_vor", ctrl_word(0,1,1,0,0,0,0,3,3), 0, 0, 0, 0, 14, 15, 16, 0, 1);
		add_row("xor_vxor", ctrl_word(0,1,1,0,0,0,0,4,4), 0, 0, 0, 0, 17, 18, 19, 0, 1);
		add_row("sll_vmul", ctrl_word(0,1,1,0,0,0,0,5,5), 16'h8421, 16'h0013, MIXED_A, MIXED_B,
			1, 2, 20, 0, 0);
		add_row("srl_vmax", ctrl_word(0,1,1,0,0,0,0,6,6), 16'h8421, 16'hfff5, MIXED_A, MIXED_B,
			1, 2, 21, 0, 0);
		add_row("slt_vmin", ctrl_word(0,1,1,0,0,0,0,7,7), 16'hff00, 16'h0001, MIXED_A, MIXED_B,
			1, 2, 22, 0, 0);
		add_row("slt_vnone", ctrl_word(0,1,1,0,0,0,0,7,11), 16'h0001, 16'hff00, MIXED_B, MIXED_A,
			1, 2, 23, 0, 0);
		add_row("pass_b", ctrl_word(0,1,1,0,0,0,0,8,0), 0, 0, 0, 0, 1, 2, 3, 0, 1);
		add_row("alu_none", ctrl_word(0,1,1,0,0,0,0,12,0), 0, 0, 0, 0, 1, 2, 4, 0, 1);
		add_row("load", ctrl_word(1,1,1,0,0,1,1,0,0), 0, 0, 0, 0, 1, 2, 7, 16'hbeef, 1);
		add_row("lane0_opb", ctrl_word(0,1,1,0,0,2,2,0,0), 0, 0, 0, 0, 1, 2, 24, 0, 1);
		add_row("zero_sel", ctrl_word(0,1,1,0,0,3,3,0,0), 0, 0, 0, 0, 1, 2, 25, 0, 1);
		add_row("fwd_make", ctrl_word(0,1,1,0,0,0,0,0,0), 0, 0, 0, 0, 1, 2, 9, 0, 1);
		add_row("fwd_both", ctrl_word(0,1,1,0,0,0,0,4,4), 0, 0, 0, 0, 9, 9, 10, 0, 1);
		add_row("fwd_rs2", ctrl_word(0,1,1,0,0,0,0,1,1), 0, 0, 0, 0, 4, 10, 11, 0, 1);
		add_row("write_r0", ctrl_word(0,1,1,0,0,0,0,0,0), 0, 0, 0, 0, 1, 2, 0, 0, 1);
		add_row("read_r0", ctrl_word(0,1,1,0,0,0,0,0,0), 0, 0, 0, 0, 0, 0, 26, 0, 1);
		add_row("no_wre", ctrl_word(0,0,0,0,0,0,0,0,0), 0, 0, 0, 0, 1, 2, 12, 0, 1);
		add_row("after_no_wre", ctrl_word(0,1,1,0,0,0,0,0,0), 0, 0, 0, 0, 12, 12, 27, 0, 1);
		add_row("mem_we_a", ctrl_word(0,0,0,1,0,0,0,0,0), 0, 0, 0, 0, 1, 2, 28, 0, 1);
		add_row("mem_we_b", ctrl_word(0,0,0,0,1,0,0,0,0), 0, 0, 0, 0, 1, 2, 29, 0, 1);
		add_row("high_bits", ctrl_word(0,1,1,1,1,0,0,0,0) | 20'he0000, 0, 0, 0, 0, 1, 2, 30, 0, 1);
		repeat (16) @(negedge clk);
		reset = 1'b0;
		// trailing bubbles drain the last rows through writeback
		for (int k = 0; k < row_count + 4; k++) begin
			apply_step(k);
			@(negedge clk);
		end
		@(posedge clk);
		$display("rows passed %0d, rows failed %0d, value errors %0d", rows_passed, rows_failed,
			error_count);
		if (error_count == 0 && rows_failed == 0 && rows_passed == row_count) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vector_execute_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module vector_execute_checker (
	input logic clk,
	input logic reset,
	input logic [`CTRL_WIDTH-1:0] control_word,
	input logic [`SCALAR_WIDTH-1:0] src_a,
	input logic [`SCALAR_WIDTH-1:0] src_b,
	input logic [`VECTOR_WIDTH-1:0] src_a_vector,
	input logic [`VECTOR_WIDTH-1:0] src_b_vector,
	input logic [`REG_ADDR_WIDTH-1:0] rs1,
	input logic [`REG_ADDR_WIDTH-1:0] rs2,
	input logic [`REG_ADDR_WIDTH-1:0] rd,
	input logic [`SCALAR_WIDTH-1:0] mem_read_data,
	input logic [`VECTOR_WIDTH-1:0] mem_vector_read_data,
	input logic wre,
	input logic vector_wre,
	input logic mem_we_a,
	input logic mem_we_b,
	input logic [`REG_ADDR_WIDTH-1:0] rd_writeback,
	input logic [`SCALAR_WIDTH-1:0] writeback_data,
	input logic [`VECTOR_WIDTH-1:0] vector_writeback_data,
	input int row_tag,
	input logic [127:0] row_name,
	output int error_count,
	output int rows_passed,
	output int rows_failed
);

	// execute stage of the model
	logic [`CTRL_WIDTH-1:0] m_ctrl;
	logic [15:0] m_a, m_b;
	logic [127:0] m_av, m_bv;
	logic [4:0] m_rs1, m_rs2, m_rd;
	int m_tag;
	logic [127:0] m_name;
	// writeback stage of the model
	logic exp_wre, exp_vwre, exp_mwa, exp_mwb;
	logic [4:0] exp_rd;
	logic [15:0] exp_data;
	logic [127:0] exp_vdata;
	int exp_tag;
	logic [127:0] exp_name;
	logic model_ready;

	function automatic logic [15:0] alu_model(input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b);
		case (op)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return a << b[3:0];
			4'd6: return a >> b[3:0];
			4'd7: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			4'd8: return b;
			default: return 16'd0;
		endcase
	endfunction

	function automatic logic [15:0] lane_model(input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b);
		case (op)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return a * b;
			4'd6: return ($signed(a) < $signed(b)) ? b : a;
			4'd7: return ($signed(a) < $signed(b)) ? a : b;
			default: return 16'd0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	initial begin
		error_count = 0;
		rows_passed = 0;
		rows_failed = 0;
		model_ready = 1'b0;
	end

	always @(posedge clk) begin : model_step
		logic [15:0] op_a, op_b, alu_out;
		logic [127:0] op_av, op_bv, lanes_out;
		logic hit_a, hit_b;
		if (reset) begin
			m_ctrl = '0;
			m_a = '0;
			m_b = '0;
			m_av = '0;
			m_bv = '0;
			m_rs1 = '0;
			m_rs2 = '0;
			m_rd = '0;
			m_name = '0;
			exp_wre = 1'b0;
			exp_vwre = 1'b0;
			exp_mwa = 1'b0;
			exp_mwb = 1'b0;
			exp_rd = '0;
			exp_data = '0;
			exp_vdata = '0;
			exp_name = '0;
			m_tag = -1;
			exp_tag = -1;
			model_ready = 1'b1;
		end else begin
			// bypass from the previous model writeback, never from register 0
			hit_a = exp_rd != 0 && exp_rd == m_rs1;
			hit_b = exp_rd != 0 && exp_rd == m_rs2;
			op_a = (exp_wre && hit_a) ? exp_data : m_a;
			op_b = (exp_wre && hit_b) ? exp_data : m_b;
			op_av = (exp_vwre && hit_a) ? exp_vdata : m_av;
			op_bv = (exp_vwre && hit_b) ? exp_vdata : m_bv;
			alu_out = alu_model(m_ctrl[`CTRL_ALU_OP], op_a, op_b);
			for (int i = 0; i < `LANE_COUNT; i++) begin
				lanes_out[16*i +: 16] = lane_model(m_ctrl[`CTRL_VECTOR_OP], op_av[16*i +: 16],
					op_bv[16*i +: 16]);
			end
			case (m_ctrl[`CTRL_WB_SEL])
				2'b00: exp_data = alu_out;
				2'b01: exp_data = mem_read_data;
				2'b10: exp_data = lanes_out[15:0];
				default: exp_data = '0;
			endcase
			case (m_ctrl[`CTRL_VECTOR_WB_SEL])
				2'b00: exp_vdata = lanes_out;
				2'b01: exp_vdata = mem_vector_read_data;
				2'b10: exp_vdata = op_bv;
				default: exp_vdata = '0;
			endcase
			exp_wre = m_ctrl[`CTRL_WRE];
			exp_vwre = m_ctrl[`CTRL_VECTOR_WRE];
			exp_mwa = m_ctrl[`CTRL_MEM_WE_A];
			exp_mwb = m_ctrl[`CTRL_MEM_WE_B];
			exp_rd = m_rd;
			exp_tag = m_tag;
			exp_name = m_name;
			m_ctrl = control_word;
			m_a = src_a;
			m_b = src_b;
			m_av = src_a_vector;
			m_bv = src_b_vector;
			m_rs1 = rs1;
			m_rs2 = rs2;
			m_rd = rd;
			m_tag = row_tag;
			m_name = row_name;
		end
	end

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin : compare_step
		int errors_before;
		if (model_ready) begin
			errors_before = error_count;
			check_value("wre", wre, exp_wre);
			check_value("vector_wre", vector_wre, exp_vwre);
			check_value("mem_we_a", mem_we_a, exp_mwa);
			check_value("mem_we_b", mem_we_b, exp_mwb);
			check_value("rd_writeback", rd_writeback, exp_rd);
			check_value("writeback_data", writeback_data, exp_data);
			check_value("vector_writeback_data", vector_writeback_data, exp_vdata);
			if (exp_tag >= 0 && error_count == errors_before) begin
				rows_passed++;
				$display("row %0d %0s ok", exp_tag, exp_name);
			end else if (exp_tag >= 0) begin
				rows_failed++;
				$display("row %0d %0s FAILED", exp_tag, exp_name);
			end
		end
	end

endmodule

`default_nettype wire

// File: vector_execute_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module vector_execute_slice
	import vector_core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CTRL_WIDTH-1:0] control_word,
	input logic [`SCALAR_WIDTH-1:0] src_a,
	input logic [`SCALAR_WIDTH-1:0] src_b,
	input logic [`VECTOR_WIDTH-1:0] src_a_vector,
	input logic [`VECTOR_WIDTH-1:0] src_b_vector,
	input logic [`REG_ADDR_WIDTH-1:0] rs1,
	input logic [`REG_ADDR_WIDTH-1:0] rs2,
	input logic [`REG_ADDR_WIDTH-1:0] rd,
	input logic [`SCALAR_WIDTH-1:0] mem_read_data,
	input logic [`VECTOR_WIDTH-1:0] mem_vector_read_data,

	output logic wre,
	output logic vector_wre,
	output logic mem_we_a,
	output logic mem_we_b,
	output logic [`REG_ADDR_WIDTH-1:0] rd_writeback,
	output logic [`SCALAR_WIDTH-1:0] writeback_data,
	output logic [`VECTOR_WIDTH-1:0] vector_writeback_data
);

	logic wre_execute;
	logic vector_wre_execute;
	logic mem_we_a_execute;
	logic mem_we_b_execute;
	wb_sel_t wb_sel_execute;
	vector_wb_sel_t vector_wb_sel_execute;
	alu_op_t alu_op_execute;
	vector_op_t vector_op_execute;
	logic [`SCALAR_WIDTH-1:0] src_a_execute;
	logic [`SCALAR_WIDTH-1:0] src_b_execute;
	logic [`VECTOR_WIDTH-1:0] src_a_vector_execute;
	logic [`VECTOR_WIDTH-1:0] src_b_vector_execute;
	logic [`REG_ADDR_WIDTH-1:0] rs1_execute;
	logic [`REG_ADDR_WIDTH-1:0] rs2_execute;
	logic [`REG_ADDR_WIDTH-1:0] rd_execute;
	logic load_instruction;

	logic [`SCALAR_WIDTH-1:0] operand_a;
	logic [`SCALAR_WIDTH-1:0] operand_b;
	logic [`VECTOR_WIDTH-1:0] operand_a_vector;
	logic [`VECTOR_WIDTH-1:0] operand_b_vector;
	logic [`SCALAR_WIDTH-1:0] alu_result;
	logic [`VECTOR_WIDTH-1:0] lane_results;

	decode_execute_register i_decode_execute (.*);

	// writeback outputs loop back as the bypass source
	forward_unit i_forward (
		.src_a_execute(src_a_execute),
		.src_b_execute(src_b_execute),
		.src_a_vector_execute(src_a_vector_execute),
		.src_b_vector_execute(src_b_vector_execute),
		.rs1_execute(rs1_execute),
		.rs2_execute(rs2_execute),
		.wre_writeback(wre),
		.vector_wre_writeback(vector_wre),
		.rd_writeback(rd_writeback),
		.writeback_data(writeback_data),
		.vector_writeback_data(vector_writeback_data),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.operand_a_vector(operand_a_vector),
		.operand_b_vector(operand_b_vector)
	);

	scalar_alu i_alu (
		.alu_op(alu_op_execute),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.alu_result(alu_result)
	);

	for (genvar i = 0; i < `LANE_COUNT; i++) begin : g_lane
		vector_lane i_lane (
			.vector_op(vector_op_execute),
			.lane_a(operand_a_vector[i*`LANE_WIDTH +: `LANE_WIDTH]),
			.lane_b(operand_b_vector[i*`LANE_WIDTH +: `LANE_WIDTH]),
			.lane_result(lane_results[i*`LANE_WIDTH +: `LANE_WIDTH])
		);
	end

	execute_writeback_register i_execute_writeback (.*);

endmodule

`default_nettype wire

// File: execute_writeback_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module execute_writeback_register
	import vector_core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wre_execute,
	input logic vector_wre_execute,
	input logic mem_we_a_execute,
	input logic mem_we_b_execute,
	input wb_sel_t wb_sel_execute,
	input vector_wb_sel_t vector_wb_sel_execute,
	input logic load_instruction,
	input logic [`REG_ADDR_WIDTH-1:0] rd_execute,
	input logic [`SCALAR_WIDTH-1:0] alu_result,
	input logic [`VECTOR_WIDTH-1:0] lane_results,
	input logic [`VECTOR_WIDTH-1:0] operand_b_vector,
	input logic [`SCALAR_WIDTH-1:0] mem_read_data,
	input logic [`VECTOR_WIDTH-1:0] mem_vector_read_data,

	output logic wre,
	output logic vector_wre,
	output logic mem_we_a,
	output logic mem_we_b,
	output logic [`REG_ADDR_WIDTH-1:0] rd_writeback,
	output logic [`SCALAR_WIDTH-1:0] writeback_data,
	output logic [`VECTOR_WIDTH-1:0] vector_writeback_data
);

	logic [`SCALAR_WIDTH-1:0] scalar_next;
	logic [`VECTOR_WIDTH-1:0] vector_next;

	always_comb begin
		case (wb_sel_execute)
			WB_ALU: scalar_next = alu_result;
			WB_LOAD: scalar_next = mem_read_data;
			WB_LANE0: scalar_next = lane_results[`LANE_WIDTH-1:0];
			default: scalar_next = '0;
		endcase
	end

	always_comb begin
		case (vector_wb_sel_execute)
			VWB_LANES: vector_next = lane_results;
			VWB_LOAD: vector_next = mem_vector_read_data;
			VWB_OPERAND_B: vector_next = operand_b_vector;
			default: vector_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wre <= 1'b0;
			vector_wre <= 1'b0;
			mem_we_a <= 1'b0;
			mem_we_b <= 1'b0;
			rd_writeback <= '0;
			writeback_data <= '0;
			vector_writeback_data <= '0;
		end else begin
			wre <= wre_execute;
			vector_wre <= vector_wre_execute;
			mem_we_a <= mem_we_a_execute;
			mem_we_b <= mem_we_b_execute;
			rd_writeback <= rd_execute;
			writeback_data <= scalar_next;
			vector_writeback_data <= vector_next;
		end
	end

	// a load that writes a register should take memory data on some side
	a_load_uses_load_data: assert property (
		@(posedge clk) disable iff (reset)
		(load_instruction && (wre_execute || vector_wre_execute))
			|-> (wb_sel_execute == WB_LOAD || vector_wb_sel_execute == VWB_LOAD)
	) else $error("execute_writeback_register: load without a load-data select");

endmodule

`default_nettype wire

// File: vector_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module vector_lane
	import vector_core_pkg::*;
(
	input vector_op_t vector_op,
	input logic [`LANE_WIDTH-1:0] lane_a,
	input logic [`LANE_WIDTH-1:0] lane_b,
	output logic [`LANE_WIDTH-1:0] lane_result
);

	// only the low half of the product is kept
	logic [`LANE_WIDTH-1:0] product;
	logic a_greater;

	assign product = lane_a * lane_b;
	// elements are two's complement for max and min
	assign a_greater = $signed(lane_a) > $signed(lane_b);

	always_comb begin
		case (vector_op)
			VEC_ADD: begin
				lane_result = lane_a + lane_b;
			end
			VEC_SUB: begin
				lane_result = lane_a - lane_b;
			end
			VEC_AND: begin
				lane_result = lane_a & lane_b;
			end
			VEC_OR: begin
				lane_result = lane_a | lane_b;
			end
			VEC_XOR: begin
				lane_result = lane_a ^ lane_b;
			end
			VEC_MUL: begin
				lane_result = product;
			end
			VEC_MAX: begin
				lane_result = a_greater ? lane_a : lane_b;
			end
			VEC_MIN: begin
				lane_result = a_greater ? lane_b : lane_a;
			end
			default: begin
				lane_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: scalar_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module scalar_alu
	import vector_core_pkg::*;
(
	input alu_op_t alu_op,
	input logic [`SCALAR_WIDTH-1:0] operand_a,
	input logic [`SCALAR_WIDTH-1:0] operand_b,
	output logic [`SCALAR_WIDTH-1:0] alu_result
);

	logic [3:0] shift_amount;
	logic less_than;

	// shifts only look at the low nibble of b
	assign shift_amount = operand_b[3:0];
	assign less_than = $signed(operand_a) < $signed(operand_b);

	always_comb begin
		case (alu_op)
			ALU_ADD: begin
				alu_result = operand_a + operand_b;
			end
			ALU_SUB: begin
				alu_result = operand_a - operand_b;
			end
			ALU_AND: begin
				alu_result = operand_a & operand_b;
			end
			ALU_OR: begin
				alu_result = operand_a | operand_b;
			end
			ALU_XOR: begin
				alu_result = operand_a ^ operand_b;
			end
			ALU_SLL: begin
				alu_result = operand_a << shift_amount;
			end
			ALU_SRL: begin
				alu_result = operand_a >> shift_amount;
			end
			ALU_SLT: begin
				alu_result = {{(`SCALAR_WIDTH-1){1'b0}}, less_than};
			end
			ALU_PASS_B: begin
				alu_result = operand_b;
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module forward_unit (
	input logic [`SCALAR_WIDTH-1:0] src_a_execute,
	input logic [`SCALAR_WIDTH-1:0] src_b_execute,
	input logic [`VECTOR_WIDTH-1:0] src_a_vector_execute,
	input logic [`VECTOR_WIDTH-1:0] src_b_vector_execute,
	input logic [`REG_ADDR_WIDTH-1:0] rs1_execute,
	input logic [`REG_ADDR_WIDTH-1:0] rs2_execute,
	input logic wre_writeback,
	input logic vector_wre_writeback,
	input logic [`REG_ADDR_WIDTH-1:0] rd_writeback,
	input logic [`SCALAR_WIDTH-1:0] writeback_data,
	input logic [`VECTOR_WIDTH-1:0] vector_writeback_data,
	output logic [`SCALAR_WIDTH-1:0] operand_a,
	output logic [`SCALAR_WIDTH-1:0] operand_b,
	output logic [`VECTOR_WIDTH-1:0] operand_a_vector,
	output logic [`VECTOR_WIDTH-1:0] operand_b_vector
);

	logic rd_nonzero;
	logic match_rs1;
	logic match_rs2;

	// register 0 is never a forwarding source
	assign rd_nonzero = rd_writeback != '0;
	assign match_rs1 = rd_nonzero && (rd_writeback == rs1_execute);
	assign match_rs2 = rd_nonzero && (rd_writeback == rs2_execute);

	assign operand_a = (wre_writeback && match_rs1) ? writeback_data : src_a_execute;
	assign operand_b = (wre_writeback && match_rs2) ? writeback_data : src_b_execute;

	// vector side uses its own write enable
	assign operand_a_vector = (vector_wre_writeback && match_rs1)
		? vector_writeback_data : src_a_vector_execute;
	assign operand_b_vector = (vector_wre_writeback && match_rs2)
		? vector_writeback_data : src_b_vector_execute;

	always_comb begin
		if (rd_writeback == '0) begin
			a_no_forward_r0: assert final (operand_a == src_a_execute)
				else $error("forward_unit: operand a bypassed from register 0");
		end
	end

endmodule

`default_nettype wire

// File: decode_execute_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_core_macros.svh"

module decode_execute_register
	import vector_core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CTRL_WIDTH-1:0] control_word,
	input logic [`SCALAR_WIDTH-1:0] src_a,
	input logic [`SCALAR_WIDTH-1:0] src_b,
	input logic [`VECTOR_WIDTH-1:0] src_a_vector,
	input logic [`VECTOR_WIDTH-1:0] src_b_vector,
	input logic [`REG_ADDR_WIDTH-1:0] rs1,
	input logic [`REG_ADDR_WIDTH-1:0] rs2,
	input logic [`REG_ADDR_WIDTH-1:0] rd,

	output logic wre_execute,
	output logic vector_wre_execute,
	output logic mem_we_a_execute,
	output logic mem_we_b_execute,
	output wb_sel_t wb_sel_execute,
	output vector_wb_sel_t vector_wb_sel_execute,
	output alu_op_t alu_op_execute,
	output vector_op_t vector_op_execute,
	output logic [`SCALAR_WIDTH-1:0] src_a_execute,
	output logic [`SCALAR_WIDTH-1:0] src_b_execute,
	output logic [`VECTOR_WIDTH-1:0] src_a_vector_execute,
	output logic [`VECTOR_WIDTH-1:0] src_b_vector_execute,
	output logic [`REG_ADDR_WIDTH-1:0] rs1_execute,
	output logic [`REG_ADDR_WIDTH-1:0] rs2_execute,
	output logic [`REG_ADDR_WIDTH-1:0] rd_execute,
	output logic load_instruction
);

	always_ff @(posedge clk) begin
		if (reset) begin
			src_a_execute <= '0;
			src_b_execute <= '0;
			src_a_vector_execute <= '0;
			src_b_vector_execute <= '0;
			rs1_execute <= '0;
			rs2_execute <= '0;
			rd_execute <= '0;

			load_instruction <= 1'b0;
			wre_execute <= 1'b0;
			vector_wre_execute <= 1'b0;
			mem_we_a_execute <= 1'b0;
			mem_we_b_execute <= 1'b0;
			wb_sel_execute <= WB_ALU;
			vector_wb_sel_execute <= VWB_LANES;
			alu_op_execute <= ALU_ADD;
			vector_op_execute <= VEC_ADD;
		end else begin
			src_a_execute <= src_a;
			src_b_execute <= src_b;
			src_a_vector_execute <= src_a_vector;
			src_b_vector_execute <= src_b_vector;
			rs1_execute <= rs1;
			rs2_execute <= rs2;
			rd_execute <= rd;

			// split the decoded word into its fields
			load_instruction <= control_word[`CTRL_LOAD];
			wre_execute <= control_word[`CTRL_WRE];
			vector_wre_execute <= control_word[`CTRL_VECTOR_WRE];
			mem_we_a_execute <= control_word[`CTRL_MEM_WE_A];
			mem_we_b_execute <= control_word[`CTRL_MEM_WE_B];
			wb_sel_execute <= wb_sel_t'(control_word[`CTRL_WB_SEL]);
			vector_wb_sel_execute <= vector_wb_sel_t'(control_word[`CTRL_VECTOR_WB_SEL]);
			alu_op_execute <= alu_op_t'(control_word[`CTRL_ALU_OP]);
			vector_op_execute <= vector_op_t'(control_word[`CTRL_VECTOR_OP]);
		end
	end

	// a reset bubble must not write or load anything downstream
	a_reset_bubble: assert property (
		@(posedge clk) reset |=> (!wre_execute && !vector_wre_execute && !mem_we_a_execute
			&& !mem_we_b_execute && !load_instruction)
	) else $error("decode_execute_register: control active after reset");

endmodule

`default_nettype wire

// File: vector_core_pkg.sv
`default_nettype none

package vector_core_pkg;

	// scalar alu opcodes, unlisted codes give zero
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SLT    = 4'd7,
		ALU_PASS_B = 4'd8
	} alu_op_t;

	// per-lane vector opcodes
	typedef enum logic [3:0] {
		VEC_ADD = 4'd0,
		VEC_SUB = 4'd1,
		VEC_AND = 4'd2,
		VEC_OR  = 4'd3,
		VEC_XOR = 4'd4,
		VEC_MUL = 4'd5,
		VEC_MAX = 4'd6,
		VEC_MIN = 4'd7
	} vector_op_t;

	typedef enum logic [1:0] {
		WB_ALU   = 2'b00,
		WB_LOAD  = 2'b01,
		// lane 0 element moved to the scalar side
		WB_LANE0 = 2'b10,
		WB_ZERO  = 2'b11
	} wb_sel_t;

	typedef enum logic [1:0] {
		VWB_LANES     = 2'b00,
		VWB_LOAD      = 2'b01,
		VWB_OPERAND_B = 2'b10,
		VWB_ZERO      = 2'b11
	} vector_wb_sel_t;

endpackage

`default_nettype wire

// File: vector_core_macros.svh
`ifndef VECTOR_CORE_MACROS_SVH
`define VECTOR_CORE_MACROS_SVH

`define SCALAR_WIDTH 16
`define VECTOR_WIDTH 128
`define LANE_WIDTH 16
`define LANE_COUNT 8
`define REG_ADDR_WIDTH 5
`define CTRL_WIDTH 20

// control word layout, bits 19..17 unused
`define CTRL_LOAD 16
`define CTRL_WRE 15
`define CTRL_VECTOR_WRE 14
`define CTRL_MEM_WE_A 13
`define CTRL_MEM_WE_B 12
`define CTRL_WB_SEL 11:10
`define CTRL_VECTOR_WB_SEL 9:8
`define CTRL_ALU_OP 7:4
`define CTRL_VECTOR_OP 3:0

`endif
